//--- verilog/sprite_cfg.svh
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// Objects walked on every line
`define SPRITE_MAXOBJ 24

// Object RAM address bits, four bytes per object
`define SPRITE_OBJ_AW 11

// Graphics ROM address made of code, row and half
`define SPRITE_ROM_AW 13

// Line buffer address bits, same as hdump
`define SPRITE_LB_AW 9

// Default horizontal offset of sprite X
`define SPRITE_HOFFSET 6

`endif

//--- verilog/sprite_pkg.sv
`default_nettype none
`include "sprite_cfg.svh"

package sprite_pkg;

    // One byte of the object table
    typedef logic [7:0] byte_t;

    // Colour or 4-bit pixel index
    typedef logic [3:0] color_t;

    // Object handed from scanner to draw engine
    typedef struct packed {
        byte_t      code;
        byte_t      xpos;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
        logic [3:0] row;   // already corrected for vflip
    } obj_entry_t;

    // Single pixel write into the line buffer
    typedef struct packed {
        logic                     we;
        logic [`SPRITE_LB_AW-1:0] addr;
        color_t                   color;
    } lb_wr_t;

    // Palette PROM download port
    typedef struct packed {
        logic   en;
        byte_t  addr;
        color_t data;
    } prom_wr_t;

endpackage

`default_nettype wire

//--- verilog/sprite_dpram.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_dpram #(
    parameter type data_t = logic [7:0],
    parameter int  aw     = 8
) (
    input  logic          clk,
    // Port 0, write and read
    input  logic          we0,
    input  logic [aw-1:0] addr0,
    input  data_t         data0,
    output data_t         q0,
    // Port 1, read only
    input  logic [aw-1:0] addr1,
    output data_t         q1
);

    data_t mem [0:(1<<aw)-1];

    // Both reads registered
    // Port 0 returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

//--- verilog/sprite_scan.sv
`timescale 1ns/1ps
`default_nettype none
`include "sprite_cfg.svh"

module sprite_scan import sprite_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hinit,
    input  byte_t                     vrender,
    output logic [`SPRITE_OBJ_AW-1:0] scan_addr,
    input  byte_t                     scan_data,
    input  logic                      busy,
    output logic                      draw,
    output obj_entry_t                obj
);

    localparam int idx_w = $clog2(`SPRITE_MAXOBJ);
    localparam int oaw   = `SPRITE_OBJ_AW;
    localparam logic [idx_w-1:0] last_obj = idx_w'(`SPRITE_MAXOBJ - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_y,
        st_code,
        st_xpos,
        st_attr,
        st_gap
    } scan_st_t;

    scan_st_t         st;
    logic             cen2;
    logic             hinit_l;
    logic             hinit_x;
    logic [idx_w-1:0] idx;
    logic [1:0]       sub;
    byte_t            y_pos;
    byte_t            y_end;
    byte_t            ydiff;
    logic             in_zone;
    logic             take;
    byte_t            code_r;
    byte_t            xpos_r;
    logic [3:0]       row_r;
    logic             inzone_r;

    // Byte address is object times four plus sub index
    assign scan_addr = oaw'({idx, sub});

    // Zone test on byte 0, Y stored inverted
    assign y_pos   = ~scan_data;
    assign y_end   = y_pos + 8'd16;
    assign ydiff   = vrender - y_pos;
    assign in_zone = (vrender >= y_pos) && (vrender < y_end);

    // Attribute step may only move on with the draw engine idle
    assign take = cen2 && (st == st_attr) && !busy;

    // Half rate enable and hinit edge catch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen2    <= 1'b0;
            hinit_l <= 1'b0;
            hinit_x <= 1'b0;
        end else begin
            cen2    <= ~cen2;
            hinit_l <= hinit;
            if (hinit && !hinit_l) begin
                hinit_x <= 1'b1;
            end else if (cen2) begin
                hinit_x <= 1'b0;
            end
        end
    end

    // Table walk, object 23 down to 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= st_idle;
            idx  <= '0;
            sub  <= '0;
            draw <= 1'b0;
        end else begin
            // Strobe lasts one clk only
            draw <= 1'b0;
            if (cen2) begin
                case (st)
                    st_idle: if (hinit_x) begin
                        idx <= last_obj;
                        sub <= 2'd0;
                        st  <= st_y;
                    end
                    st_y: begin
                        sub <= sub + 2'd1;
                        st  <= st_code;
                    end
                    st_code: begin
                        sub <= sub + 2'd1;
                        st  <= st_xpos;
                    end
                    st_xpos: begin
                        sub <= sub + 2'd1;
                        st  <= st_attr;
                    end
                    st_attr: if (!busy) begin
                        draw <= inzone_r;
                        sub  <= 2'd0;
                        idx  <= idx - 1'b1;
                        st   <= (idx == '0) ? st_idle : st_gap;
                    end
                    // Leaves room for busy to rise
                    st_gap: st <= st_y;
                    default: st <= st_idle;
                endcase
            end
        end
    end

    // Object fields as they come out of RAM
    always_ff @(posedge clk) begin
        if (cen2 && st == st_y) begin
            inzone_r <= in_zone;
            row_r    <= ydiff[3:0];
        end
        if (cen2 && st == st_code) begin
            code_r <= scan_data;
        end
        if (cen2 && st == st_xpos) begin
            xpos_r <= scan_data;
        end
        if (take) begin
            obj.code  <= code_r;
            obj.xpos  <= xpos_r;
            obj.pal   <= scan_data[3:0];
            obj.hflip <= scan_data[6];
            obj.vflip <= scan_data[7];
            // Row counts upward from the bottom when flipped
            obj.row   <= row_r ^ {4{scan_data[7]}};
        end
    end

endmodule

`default_nettype wire

//--- verilog/sprite_draw.sv
`timescale 1ns/1ps
`default_nettype none
`include "sprite_cfg.svh"

module sprite_draw import sprite_pkg::*; #(
    parameter int hoffset = `SPRITE_HOFFSET
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      draw,
    input  obj_entry_t                obj,
    output logic                      busy,
    input  prom_wr_t                  prom,
    output logic [`SPRITE_ROM_AW-1:0] rom_addr,
    output logic                      rom_cs,
    input  logic [31:0]               rom_data,
    input  logic                      rom_ok,
    output lb_wr_t                    lb_wr
);

    localparam int lb_aw = `SPRITE_LB_AW;

    typedef enum logic [1:0] {st_idle, st_fetch, st_shift} draw_st_t;

    draw_st_t         st;
    logic             half;
    logic [2:0]       k;
    logic             pipe_vld;
    logic             pipe_last;
    logic [lb_aw-1:0] pipe_addr;
    byte_t            code_r;
    byte_t            xpos_r;
    logic [3:0]       pal_r;
    logic             hflip_r;
    logic [3:0]       row_r;
    logic [31:0]      sr;
    color_t           nibble;
    color_t           pal_q;
    logic [3:0]       col;

    // Destination column grows monotonically, flip only changes fetch order
    assign col      = {half, k};
    assign rom_addr = {code_r, row_r, half ^ hflip_r};
    assign nibble   = hflip_r ? sr[31:28] : sr[3:0];

    // Palette PROM, pal in the high nibble
    sprite_dpram #(
        .data_t ( color_t ),
        .aw     ( 8       )
    ) u_pal (
        .clk    ( clk             ),
        .we0    ( prom.en         ),
        .addr0  ( prom.addr       ),
        .data0  ( prom.data       ),
        .q0     (                 ),
        .addr1  ( {pal_r, nibble} ),
        .q1     ( pal_q           )
    );

    // Colour 0 is transparent
    assign lb_wr.we    = pipe_vld && (pal_q != '0);
    assign lb_wr.addr  = pipe_addr;
    assign lb_wr.color = pal_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= st_idle;
            busy      <= 1'b0;
            rom_cs    <= 1'b0;
            half      <= 1'b0;
            k         <= '0;
            pipe_vld  <= 1'b0;
            pipe_last <= 1'b0;
        end else begin
            pipe_vld  <= 1'b0;
            pipe_last <= 1'b0;
            // Done once the last pixel leaves the palette stage
            if (pipe_vld && pipe_last) begin
                busy <= 1'b0;
            end
            case (st)
                st_idle: if (draw) begin
                    busy   <= 1'b1;
                    rom_cs <= 1'b1;
                    half   <= 1'b0;
                    st     <= st_fetch;
                end
                // Address held steady until the ROM answers
                st_fetch: if (rom_ok) begin
                    rom_cs <= 1'b0;
                    k      <= '0;
                    st     <= st_shift;
                end
                st_shift: begin
                    pipe_vld  <= 1'b1;
                    pipe_last <= half && (k == 3'd7);
                    k         <= k + 3'd1;
                    if (k == 3'd7) begin
                        if (half) begin
                            st <= st_idle;
                        end else begin
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            st     <= st_fetch;
                        end
                    end
                end
                default: st <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == st_idle && draw) begin
            code_r  <= obj.code;
            xpos_r  <= obj.xpos;
            pal_r   <= obj.pal;
            hflip_r <= obj.hflip;
            row_r   <= obj.row;
        end
        // Flipped words shift out from the top nibble
        if (st == st_fetch && rom_ok) begin
            sr <= rom_data;
        end else if (st == st_shift) begin
            sr <= hflip_r ? (sr << 4) : (sr >> 4);
        end
        // Wraps at the line buffer size
        pipe_addr <= lb_aw'(xpos_r) + lb_aw'(hoffset) + lb_aw'(col);
    end

endmodule

`default_nettype wire

//--- verilog/sprite_linebuf.sv
`timescale 1ns/1ps
`default_nettype none
`include "sprite_cfg.svh"

module sprite_linebuf import sprite_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hinit,
    input  logic                     pxl_cen,
    input  logic [`SPRITE_LB_AW-1:0] hdump,
    input  lb_wr_t                   lb_wr,
    output color_t                   pxl
);

    logic   hinit_l;
    logic   hinit_rise;
    logic   bank;
    logic   cur_bank;
    logic   rd_vld;
    logic   rd_bank;
    color_t rd_q [2];

    assign hinit_rise = hinit && !hinit_l;

    // New display bank already valid on the hinit edge itself
    assign cur_bank = bank ^ hinit_rise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hinit_l <= 1'b0;
            bank    <= 1'b0;
            rd_vld  <= 1'b0;
            rd_bank <= 1'b0;
        end else begin
            hinit_l <= hinit;
            bank    <= cur_bank;
            rd_vld  <= pxl_cen;
            rd_bank <= cur_bank;
        end
    end

    // cur_bank selects the display bank, the other one takes draw writes
    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic disp;

        assign disp = (cur_bank == 1'(b));

        // Display side clears each entry as it is read
        sprite_dpram #(
            .data_t ( color_t       ),
            .aw     ( `SPRITE_LB_AW )
        ) u_ram (
            .clk    ( clk                             ),
            .we0    ( disp ? pxl_cen : lb_wr.we       ),
            .addr0  ( disp ? hdump : lb_wr.addr       ),
            .data0  ( disp ? color_t'(0) : lb_wr.color ),
            .q0     (                                 ),
            .addr1  ( hdump                           ),
            .q1     ( rd_q[b]                         )
        );
    end

    // Pixel shows on the cycle after pxl_cen
    assign pxl = rd_vld ? rd_q[rd_bank] : '0;

endmodule

`default_nettype wire

//--- verilog/sprite_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "sprite_cfg.svh"

module sprite_engine import sprite_pkg::*; #(
    parameter int hoffset = `SPRITE_HOFFSET
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    // CPU port
    input  logic [`SPRITE_OBJ_AW-1:0] cpu_addr,
    input  byte_t                     cpu_dout,
    input  logic                      oram_cs,
    input  logic                      cpu_rnw,
    output byte_t                     obj_dout,
    // Video timing
    input  logic                      hinit,
    input  byte_t                     vrender,
    input  logic [`SPRITE_LB_AW-1:0]  hdump,
    // Palette download
    input  color_t                    prog_data,
    input  byte_t                     prog_addr,
    input  logic                      prog_en,
    // Graphics ROM
    output logic [`SPRITE_ROM_AW-1:0] rom_addr,
    input  logic [31:0]               rom_data,
    output logic                      rom_cs,
    input  logic                      rom_ok,
    output color_t                    pxl
);

    logic [`SPRITE_OBJ_AW-1:0] scan_addr;
    byte_t                     scan_data;
    logic                      obj_we;
    logic                      draw;
    logic                      busy;
    obj_entry_t                obj;
    prom_wr_t                  prom;
    lb_wr_t                    lb_wr;

    assign obj_we    = oram_cs && !cpu_rnw;
    assign prom.en   = prog_en;
    assign prom.addr = prog_addr;
    assign prom.data = prog_data;

    // Object table, CPU on port 0 and scanner on port 1
    sprite_dpram #(
        .data_t ( byte_t         ),
        .aw     ( `SPRITE_OBJ_AW )
    ) u_oram (
        .clk    ( clk       ),
        .we0    ( obj_we    ),
        .addr0  ( cpu_addr  ),
        .data0  ( cpu_dout  ),
        .q0     ( obj_dout  ),
        .addr1  ( scan_addr ),
        .q1     ( scan_data )
    );

    sprite_scan u_scan (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hinit     ( hinit     ),
        .vrender   ( vrender   ),
        .scan_addr ( scan_addr ),
        .scan_data ( scan_data ),
        .busy      ( busy      ),
        .draw      ( draw      ),
        .obj       ( obj       )
    );

    sprite_draw #(
        .hoffset ( hoffset )
    ) u_draw (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .draw     ( draw     ),
        .obj      ( obj      ),
        .busy     ( busy     ),
        .prom     ( prom     ),
        .rom_addr ( rom_addr ),
        .rom_cs   ( rom_cs   ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .lb_wr    ( lb_wr    )
    );

    sprite_linebuf u_linebuf (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .hinit   ( hinit   ),
        .pxl_cen ( pxl_cen ),
        .hdump   ( hdump   ),
        .lb_wr   ( lb_wr   ),
        .pxl     ( pxl     )
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_sprite_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "sprite_cfg.svh"

module tb_sprite_engine import sprite_pkg::*; ();

    localparam int hoff       = `SPRITE_HOFFSET;
    localparam int nobj       = `SPRITE_MAXOBJ;
    localparam int line_cyc   = 1024;
    // Twelve lines plus palette and table loading
    localparam int max_cycles = 12 * line_cyc + 3712;

    logic                      clk;
    logic                      rst;
    logic                      pxl_cen;
    logic [`SPRITE_OBJ_AW-1:0] cpu_addr;
    byte_t                     cpu_dout;
    logic                      oram_cs;
    logic                      cpu_rnw;
    byte_t                     obj_dout;
    logic                      hinit;
    byte_t                     vrender;
    logic [`SPRITE_LB_AW-1:0]  hdump;
    color_t                    prog_data;
    byte_t                     prog_addr;
    logic                      prog_en;
    logic [`SPRITE_ROM_AW-1:0] rom_addr;
    logic [31:0]               rom_data = '0;
    logic                      rom_cs;
    logic                      rom_ok = 1'b0;
    color_t                    pxl;

    // Shadow of the object table
    byte_t      oram [0:4*nobj-1];
    // Line being drawn and line on display
    color_t     exp_next [0:511];
    color_t     exp_disp [0:511];
    color_t     exp_pxl    = '0;
    logic       chk_en     = 1'b0;
    logic [8:0] chk_addr   = '0;
    logic       line_chk   = 1'b0;
    logic       rom_nowait = 1'b1;
    logic       rom_pend   = 1'b0;
    int         rom_wait   = 0;
    int         rom_delay;
    int         errors     = 0;
    int         pix_checks = 0;
    int         cycles     = 0;
    byte_t      vr         = 8'd40;
    string      test_name  = "reset";

    tb_clock u_clock (
        .clk ( clk ),
        .rst ( rst )
    );

    sprite_engine #(
        .hoffset ( hoff )
    ) UUT (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .oram_cs   ( oram_cs   ),
        .cpu_rnw   ( cpu_rnw   ),
        .obj_dout  ( obj_dout  ),
        .hinit     ( hinit     ),
        .vrender   ( vrender   ),
        .hdump     ( hdump     ),
        .prog_data ( prog_data ),
        .prog_addr ( prog_addr ),
        .prog_en   ( prog_en   ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_cs    ( rom_cs    ),
        .rom_ok    ( rom_ok    ),
        .pxl       ( pxl       )
    );

    // Graphics ROM contents, fixed hash of the address
    function automatic logic [31:0] rom_word(input logic [12:0] a);
        logic [31:0] h;
        h = ({19'd0, a} + 32'd1) * 32'h9e3779b1;
        return h ^ (h >> 15);
    endfunction

    // Pixel xor pal, pixel 0 always transparent
    function automatic color_t pal_color(input byte_t a);
        return (a[3:0] == 4'd0) ? 4'd0 : (a[3:0] ^ a[7:4]);
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout, run still going after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ROM answers each request after 0 to 5 cycles
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_pend <= 1'b0;
        end else begin
            rom_ok <= 1'b0;
            // Answer already taken on this edge
            if (rom_cs && !rom_ok) begin
                if (!rom_pend) begin
                    rom_delay = rom_nowait ? 0 : int'($urandom % 6);
                end else begin
                    rom_delay = rom_wait;
                end
                if (rom_delay == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                    rom_pend <= 1'b0;
                end else begin
                    rom_pend <= 1'b1;
                    rom_wait <= rom_delay - 1;
                end
            end
        end
    end

    // Expected pixel lines up one cycle after pxl_cen
    always @(posedge clk) begin
        chk_en   <= pxl_cen && line_chk;
        chk_addr <= hdump;
        exp_pxl  <= exp_disp[hdump];
        if (chk_en) begin
            pix_checks <= pix_checks + 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) chk_en |-> pxl === exp_pxl)
        else begin
            errors++;
            $display("FAILED %s hdump %0d expected %h actual %h",
                     test_name, $sampled(chk_addr), $sampled(exp_pxl), $sampled(pxl));
        end

    // Request level and address held until rom_ok
    assert property (@(posedge clk) disable iff (rst)
                     rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            errors++;
            $display("ROM request dropped or its address moved before rom_ok");
        end

    task automatic cpu_write(input int a, input byte_t d);
        @(posedge clk);
        cpu_addr <= 11'(a);
        cpu_dout <= d;
        oram_cs  <= 1'b1;
        cpu_rnw  <= 1'b0;
    endtask

    task automatic cpu_idle();
        @(posedge clk);
        oram_cs <= 1'b0;
        cpu_rnw <= 1'b1;
    endtask

    task automatic cpu_readback(input int a, input byte_t d);
        cpu_write(a, d);
        @(posedge clk);
        cpu_rnw <= 1'b1;
        cpu_idle();
        // Read address went out one cycle ago
        @(negedge clk);
        assert (obj_dout === d)
            else begin
                errors++;
                $display("FAILED %s addr %h expected %h actual %h",
                         test_name, 11'(a), d, obj_dout);
            end
    endtask

    task automatic put_byte(input int a, input byte_t d);
        oram[a] = d;
        cpu_write(a, d);
    endtask

    // Y goes in stored inverted
    task automatic write_obj(input int o, input byte_t y, input byte_t code,
                             input byte_t x, input byte_t attr);
        put_byte(4 * o, ~y);
        put_byte(4 * o + 1, code);
        put_byte(4 * o + 2, x);
        put_byte(4 * o + 3, attr);
        cpu_idle();
    endtask

    // Y of 200 stays out of every line used here
    task automatic clear_table();
        int o;
        for (o = 0; o < nobj; o++) begin
            write_obj(o, 8'd200, 8'd0, 8'd0, 8'd0);
        end
    endtask

    task automatic load_palette();
        int a;
        for (a = 0; a < 256; a++) begin
            @(posedge clk);
            prog_en   <= 1'b1;
            prog_addr <= 8'(a);
            prog_data <= pal_color(8'(a));
        end
        @(posedge clk);
        prog_en <= 1'b0;
    endtask

    // Reference line, lower index drawn last so it wins
    task automatic build_line(input byte_t v);
        byte_t       y;
        byte_t       attr;
        logic [3:0]  row;
        logic [3:0]  src;
        logic [31:0] w;
        color_t      c;
        int          i;
        int          o;
        int          col;
        for (i = 0; i < 512; i++) begin
            exp_next[i] = '0;
        end
        for (o = nobj - 1; o >= 0; o--) begin
            y    = ~oram[4*o];
            attr = oram[4*o+3];
            // Zone in 8-bit arithmetic, end may wrap
            if (v >= y && v < byte_t'(y + 8'd16)) begin
                row = 4'(v - y) ^ {4{attr[7]}};
                for (col = 0; col < 16; col++) begin
                    src = attr[6] ? 4'(15 - col) : 4'(col);
                    w   = rom_word({oram[4*o+1], row, src[3]});
                    c   = pal_color({attr[3:0], w[4*src[2:0] +: 4]});
                    if (c != '0) begin
                        exp_next[9'(oram[4*o+2] + col + hoff)] = c;
                    end
                end
            end
        end
    endtask

    // 384 visible and 128 blank pixels, pxl_cen every second cycle
    task automatic run_line(input logic chk);
        int lc;
        for (lc = 0; lc < line_cyc; lc++) begin
            @(posedge clk);
            if (lc == 0) begin
                // Bank drawn last line goes on display
                exp_disp = exp_next;
                line_chk = chk;
                build_line(vr);
                vrender <= vr;
            end
            hdump   <= 9'(lc / 2);
            pxl_cen <= (lc % 2 == 0);
            hinit   <= (lc < 2);
        end
        vr = vr + 8'd1;
    endtask

    initial begin
        void'($urandom(32'h4e91d4d9));
        pxl_cen   <= 1'b0;
        cpu_addr  <= '0;
        cpu_dout  <= '0;
        oram_cs   <= 1'b0;
        cpu_rnw   <= 1'b1;
        hinit     <= 1'b0;
        vrender   <= '0;
        hdump     <= '0;
        prog_data <= '0;
        prog_addr <= '0;
        prog_en   <= 1'b0;
        wait (rst === 1'b0);
        @(negedge clk);
        assert (rom_cs === 1'b0 && pxl === 4'd0)
            else begin
                errors++;
                $display("rom_cs or pxl not low after reset");
            end

        test_name = "cpu_readback";
        repeat (16) cpu_readback(int'($urandom % 2048), 8'($urandom));
        load_palette();

        // First two displayed lines come from uncleared banks
        test_name = "empty_line";
        clear_table();
        run_line(1'b0);
        run_line(1'b0);
        run_line(1'b1);

        test_name = "single_object";
        rom_nowait = 1'b1;
        write_obj(7, 8'd40, 8'h3c, 8'd100, 8'h05);
        run_line(1'b1);
        run_line(1'b1);

        test_name = "flip";
        rom_nowait = 1'b0;
        clear_table();
        write_obj(3, 8'd38, 8'h51, 8'd20, 8'h46);
        write_obj(9, 8'd38, 8'h52, 8'd60, 8'h8a);
        write_obj(12, 8'd44, 8'h51, 8'd200, 8'hc7);
        run_line(1'b1);
        run_line(1'b1);

        // Out of zone, wrapped zone and a three-way overlap
        test_name = "overlap";
        clear_table();
        write_obj(15, 8'd100, 8'h77, 8'd150, 8'h02);
        write_obj(21, 8'd250, 8'h66, 8'd10, 8'h05);
        write_obj(6, 8'd44, 8'h22, 8'd156, 8'h49);
        write_obj(2, 8'd40, 8'h11, 8'd150, 8'h03);
        write_obj(0, 8'd48, 8'h33, 8'd160, 8'h8c);
        run_line(1'b1);
        run_line(1'b1);

        test_name = "nowait_same";
        rom_nowait = 1'b1;
        run_line(1'b1);
        run_line(1'b1);

        repeat (4) @(posedge clk);
        $display("Done: %0d pixel checks, %0d errors", pix_checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sprite_engine.f
+incdir+verilog
verilog/sprite_pkg.sv
verilog/sprite_dpram.sv
verilog/sprite_scan.sv
verilog/sprite_draw.sv
verilog/sprite_linebuf.sv
verilog/sprite_engine.sv
testbench/tb_clock.sv
testbench/tb_sprite_engine.sv

//--- Bender.yml
package:
  name: sprite_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sprite_pkg.sv
      - verilog/sprite_dpram.sv
      - verilog/sprite_scan.sv
      - verilog/sprite_draw.sv
      - verilog/sprite_linebuf.sv
      - verilog/sprite_engine.sv
      - target: test
        files:
          - testbench/tb_clock.sv
          - testbench/tb_sprite_engine.sv
